//--- src/mips_isa_pkg.sv
package mips_isa_pkg;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SB      = 6'h28
    } opcode_e;

    // Function codes under OP_SPECIAL
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef logic [4:0] reg_idx_t;

    // Low 16 bits (rd, shamt, funct) double as the I-type immediate
    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        funct_e     funct;
    } instr_t;

endpackage

//--- src/avalon_pkg.sv
package avalon_pkg;

    localparam int ADDR_W = 32;  // Byte address
    localparam int DATA_W = 32;

    // Master to slave
    typedef struct packed {
        logic [ADDR_W-1:0]   address;
        logic                read;
        logic                write;
        logic [DATA_W-1:0]   writedata;
        logic [DATA_W/8-1:0] byteenable;
    } avalon_req_t;

    // Slave to master
    typedef struct packed {
        logic              waitrequest;
        logic [DATA_W-1:0] readdata;
    } avalon_rsp_t;

endpackage

//--- src/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mips_isa_pkg::reg_idx_t rs_addr,
    input  mips_isa_pkg::reg_idx_t rt_addr,
    output logic [31:0]            rs_data,
    output logic [31:0]            rt_data,
    input  logic                   wr_en,
    input  mips_isa_pkg::reg_idx_t wr_addr,
    input  logic [31:0]            wr_data,
    output logic [31:0]            v0
);
    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin  // $zero is never written
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous read ports
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    assign v0 = regs[2];  // $v0 tap for the top level

endmodule

//--- src/mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
    input  mips_isa_pkg::alu_op_e op,
    input  logic [31:0]           a,
    input  logic [31:0]           b,
    output logic [31:0]           result,
    output logic                  equal
);
    import mips_isa_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;  // Wraps, no overflow trap
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
            default: result = a + b;
        endcase
    end

    // Branch compare for BEQ and BNE
    assign equal = (a == b);

endmodule

//--- src/mips_cpu.sv
`timescale 1ns/1ps

module mips_cpu #(
    parameter logic [31:0] RESET_PC = 32'h4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output avalon_pkg::avalon_req_t bus_req,
    input  avalon_pkg::avalon_rsp_t bus_rsp,
    output logic                    active,
    output logic [31:0]             register_v0
);
    import mips_isa_pkg::*;
    import avalon_pkg::*;

    typedef enum logic [2:0] {FETCH, DECODE, EXEC, MEM, WB} state_e;

    state_e            state;
    instr_t            instr_q;
    logic [ADDR_W-1:0] pc, pending_target;
    logic              pending, started;
    logic [DATA_W-1:0] a_q, b_q, rt_q, result_q;
    logic [DATA_W-1:0] rs_data, rt_data, alu_result, imm_ext, branch_target;
    logic [15:0]       imm;
    logic              alu_equal, use_imm, rtype_alu, is_mem, reg_write;
    logic              take_branch, done;
    alu_op_e           alu_op;
    reg_idx_t          wr_addr;

    // ################################################
    // Decode
    // ################################################
    assign imm           = {instr_q.rd, instr_q.shamt, instr_q.funct};
    assign imm_ext       = {{16{imm[15]}}, imm};
    assign branch_target = pc + 32'd4 + {imm_ext[29:0], 2'b00};  // Relative to delay slot

    always_comb begin
        alu_op    = ALU_ADD;
        rtype_alu = 1'b0;
        if (instr_q.opcode == OP_SPECIAL) begin
            rtype_alu = 1'b1;
            case (instr_q.funct)
                FN_ADDU: alu_op = ALU_ADD;
                FN_SUBU: alu_op = ALU_SUB;
                FN_AND:  alu_op = ALU_AND;
                FN_OR:   alu_op = ALU_OR;
                FN_SLT:  alu_op = ALU_SLT;
                default: rtype_alu = 1'b0;  // JR and unknown codes write nothing
            endcase
        end
    end

    assign use_imm   = instr_q.opcode inside {OP_ADDIU, OP_LW, OP_SB};
    assign is_mem    = instr_q.opcode inside {OP_LW, OP_SB};
    assign reg_write = rtype_alu || (instr_q.opcode inside {OP_ADDIU, OP_LW});
    assign wr_addr   = rtype_alu ? instr_q.rd : instr_q.rt;

    always_comb begin
        case (instr_q.opcode)
            OP_BEQ:     take_branch = alu_equal;
            OP_BNE:     take_branch = !alu_equal;
            OP_SPECIAL: take_branch = (instr_q.funct == FN_JR);
            default:    take_branch = 1'b0;
        endcase
    end

    // Last cycle of the current instruction
    always_comb begin
        case (state)
            EXEC:    done = !reg_write && !is_mem;  // Branches, JR, no-ops
            MEM:     done = (instr_q.opcode == OP_SB) && !bus_rsp.waitrequest;
            WB:      done = 1'b1;
            default: done = 1'b0;
        endcase
    end

    // ################################################
    // Control and PC
    // ################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= FETCH;
            pc      <= RESET_PC;
            pending <= 1'b0;
            started <= 1'b0;
            active  <= 1'b1;
        end else begin
            started <= 1'b1;  // Holds the bus idle for the first cycle
            if (done) begin
                if (state == EXEC && take_branch) begin
                    pending <= 1'b1;  // Delay slot runs first
                    pc      <= pc + 32'd4;
                end else if (pending) begin
                    pending <= 1'b0;
                    pc      <= pending_target;
                    if (pending_target == '0) begin
                        active <= 1'b0;  // JR to 0 halts
                    end
                end else begin
                    pc <= pc + 32'd4;
                end
            end
            case (state)
                FETCH:   if (bus_req.read && !bus_rsp.waitrequest) state <= DECODE;
                DECODE:  state <= EXEC;
                EXEC:    state <= is_mem ? MEM : (reg_write ? WB : FETCH);
                MEM:     if (!bus_rsp.waitrequest) state <= bus_req.read ? WB : FETCH;
                default: state <= FETCH;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (state == FETCH && bus_req.read && !bus_rsp.waitrequest) begin
            instr_q <= instr_t'(bus_rsp.readdata);
        end
        if (state == DECODE) begin
            a_q  <= rs_data;
            b_q  <= use_imm ? imm_ext : rt_data;
            rt_q <= rt_data;  // Store data for SB
        end
        if (state == EXEC) begin
            result_q <= alu_result;
            if (take_branch) begin
                pending_target <= (instr_q.opcode == OP_SPECIAL) ? a_q : branch_target;
            end
        end
        if (state == MEM && bus_req.read && !bus_rsp.waitrequest) begin
            result_q <= bus_rsp.readdata;  // LW data
        end
    end

    // Bus master, held stable until waitrequest drops
    always_comb begin
        bus_req = '0;
        if (started && active) begin
            if (state == FETCH) begin
                bus_req.address    = pc;
                bus_req.read       = 1'b1;
                bus_req.byteenable = '1;
            end else if (state == MEM) begin
                bus_req.address    = result_q;
                bus_req.read       = (instr_q.opcode == OP_LW);
                bus_req.write      = (instr_q.opcode == OP_SB);
                bus_req.writedata  = {4{rt_q[7:0]}};  // Byte on every lane
                bus_req.byteenable = bus_req.read ? 4'hf : 4'b0001 << result_q[1:0];
            end
        end
    end

    mips_regfile regfile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (instr_q.rs),
        .rt_addr (instr_q.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (state == WB && reg_write),
        .wr_addr (wr_addr),
        .wr_data (result_q),
        .v0      (register_v0)
    );

    mips_alu alu_i (
        .op     (alu_op),
        .a      (a_q),
        .b      (b_q),
        .result (alu_result),
        .equal  (alu_equal)
    );

endmodule

//--- src/avalon_ram.sv
`timescale 1ns/1ps

module avalon_ram #(
    parameter int RAM_ADDR_W = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  avalon_pkg::avalon_req_t bus_req,
    output avalon_pkg::avalon_rsp_t bus_rsp,
    input  logic                    load_en,
    input  logic [31:0]             load_addr,
    input  logic [31:0]             load_data
);
    import avalon_pkg::*;

    localparam int BYTES = DATA_W / 8;

    logic [DATA_W-1:0]     mem [2**RAM_ADDR_W];
    logic [RAM_ADDR_W-1:0] bus_idx, load_idx;
    logic                  wait_done;

    assign bus_idx  = bus_req.address[RAM_ADDR_W+1:2];  // Word index
    assign load_idx = load_addr[RAM_ADDR_W+1:2];

    // ################################################
    // Read wait state
    // ################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_done <= 1'b0;
        end else begin
            wait_done <= bus_req.read && !wait_done;
        end
    end

    assign bus_rsp.waitrequest = bus_req.read && !wait_done;  // Writes never wait
    assign bus_rsp.readdata    = mem[bus_idx];

    // Program load port takes priority over the bus
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end else if (bus_req.write) begin
            for (int i = 0; i < BYTES; i++) begin
                if (bus_req.byteenable[i]) begin
                    mem[bus_idx][8*i +: 8] <= bus_req.writedata[8*i +: 8];
                end
            end
        end
    end

endmodule

//--- src/mips_system.sv
`timescale 1ns/1ps

module mips_system #(
    parameter int          RAM_ADDR_W = 8,
    parameter logic [31:0] RESET_PC   = 32'h4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    output logic        active,
    output logic [31:0] register_v0
);
    import avalon_pkg::*;

    avalon_req_t bus_req;  // CPU to RAM
    avalon_rsp_t bus_rsp;

    mips_cpu #(
        .RESET_PC (RESET_PC)
    ) cpu_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .active      (active),
        .register_v0 (register_v0)
    );

    avalon_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) ram_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

//--- tb/mips_system_props.sv
`timescale 1ns/1ps

module mips_system_props (
    input logic                    clk,
    input logic                    rst_n,
    input avalon_pkg::avalon_req_t bus_req,
    input avalon_pkg::avalon_rsp_t bus_rsp,
    input logic                    active
);
    int unsigned error_count = 0;  // Failed assertions so far

    // Master holds the whole request while the slave stalls it
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_req.read || bus_req.write) && bus_rsp.waitrequest |=> $stable(bus_req))
    else begin
        $error("Bus request changed while waitrequest was high");
        error_count++;
    end

    rd_wr_exclusive: assert property (@(posedge clk) !(bus_req.read && bus_req.write))
    else begin
        $error("Read and write were high in the same cycle");
        error_count++;
    end

    idle_in_reset: assert property (@(posedge clk) !rst_n |-> !bus_req.read && !bus_req.write)
    else begin
        $error("Bus transfer requested while reset was low");
        error_count++;
    end

    // Only a reset may bring the CPU back to life
    active_no_rise: assert property (@(posedge clk) $rose(active) |-> !rst_n)
    else begin
        $error("Active rose outside of reset");
        error_count++;
    end

endmodule

bind mips_system mips_system_props props_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .active  (active)
);

//--- tb/mips_system_tb.sv
`timescale 1ns/1ps

module mips_system_tb;

    localparam logic [31:0] RESET_PC    = 32'h4;
    localparam logic [31:0] DATA_ADDR   = 32'h200;
    localparam logic [31:0] DATA_INIT   = 32'ha1b2c3d4;
    localparam int          PERIOD_NS   = 40;
    localparam int          LOOPS       = 4;
    localparam int          WATCHDOG_NS = 3 * 40 * 8 * PERIOD_NS;  // Programs, instrs, cycles

    // Instruction encodings
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SB      = 6'h28;
    localparam logic [5:0] FN_JR       = 6'h08;
    localparam logic [5:0] FN_ADDU     = 6'h21;
    localparam logic [5:0] FN_SUBU     = 6'h23;
    localparam logic [5:0] FN_AND      = 6'h24;
    localparam logic [5:0] FN_OR       = 6'h25;
    localparam logic [5:0] FN_SLT      = 6'h2a;

    localparam logic [4:0] ZERO = 5'd0;
    localparam logic [4:0] V0   = 5'd2;
    localparam logic [4:0] T0   = 5'd8;
    localparam logic [4:0] T1   = 5'd9;
    localparam logic [4:0] T2   = 5'd10;
    localparam logic [4:0] S0   = 5'd16;
    localparam logic [4:0] S1   = 5'd17;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        load_en;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] code [$];  // Program image, placed from RESET_PC up

    mips_system #(
        .RAM_ADDR_W (8),
        .RESET_PC   (RESET_PC)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .active      (active),
        .register_v0 (register_v0)
    );

    always #(PERIOD_NS / 2) clk = ~clk;

    // ################################################
    // Program assembly
    // ################################################
    function automatic logic [31:0] sext(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] r_type(input logic [5:0] funct, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {OPC_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic void emit(input logic [31:0] word);
        code.push_back(word);
    endfunction

    function automatic logic [31:0] here();
        return RESET_PC + 32'(4 * code.size());
    endfunction

    // Branch offset in words, counted from the delay slot
    function automatic logic [15:0] offset_to(input logic [31:0] target);
        logic [31:0] delta;
        delta = target - (here() + 32'd4);
        return delta[17:2];
    endfunction

    // ################################################
    // Run control
    // ################################################
    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        load_en   <= 1'b1;
        load_addr <= addr;
        load_data <= data;
    endtask

    // Entered with reset low, leaves with reset low again
    task automatic run_program(input string name, input logic [31:0] expected);
        repeat (5) @(posedge clk);
        foreach (code[i]) begin
            load_word(RESET_PC + 32'(4 * i), code[i]);
        end
        load_word(DATA_ADDR, DATA_INIT);
        @(posedge clk);
        load_en <= 1'b0;
        rst_n   <= 1'b1;
        @(negedge clk);
        while (active) begin
            @(negedge clk);
        end
        assert (register_v0 === expected) else begin
            $display("CHECK FAILED at %0t: register_v0 = %h, expected %h (%s)",
                     $time, register_v0, expected, name);
            stop_on_failure();
        end
        $display("%s halted with v0 = %h", name, register_v0);
        code.delete();
        @(posedge clk);
        rst_n <= 1'b0;
    endtask

    always @(dut_i.props_i.error_count) begin
        if (dut_i.props_i.error_count != 0) begin
            $display("A bus property assertion failed at %0t", $time);
            stop_on_failure();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the CPU never halted", WATCHDOG_NS);
        stop_on_failure();
    end

    initial begin
        logic [31:0] expected;
        logic [15:0] chain [5];
        logic [31:0] loop_pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] mem_word;

        rst_n     = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        rst_n     <= 1'b0;  // Falling edge at time 0 starts the reset

        // ADDIU chain with negative immediates, last one in the JR delay slot
        chain    = '{16'h8000, 16'h8000, 16'h7fff, 16'hfff0, 16'h0123};
        expected = '0;
        foreach (chain[k]) begin
            expected = expected + sext(chain[k]);
        end
        emit(i_type(OPC_ADDIU, ZERO, V0, chain[0]));
        for (int k = 1; k < 4; k++) begin
            emit(i_type(OPC_ADDIU, V0, V0, chain[k]));
        end
        emit(r_type(FN_JR, ZERO, ZERO, ZERO));
        emit(i_type(OPC_ADDIU, V0, V0, chain[4]));
        emit(i_type(OPC_ADDIU, V0, V0, 16'h1000));  // Past the halt
        run_program("addiu_chain", expected);

        // Branches and delay slots
        emit(i_type(OPC_ADDIU, ZERO, V0, 16'd1));
        emit(i_type(OPC_BEQ, ZERO, ZERO, offset_to(here() + 32'd16)));  // Taken
        emit(i_type(OPC_ADDIU, V0, V0, 16'd2));
        emit(i_type(OPC_ADDIU, V0, V0, 16'h0100));  // Skipped
        emit(i_type(OPC_ADDIU, V0, V0, 16'h0200));  // Skipped
        emit(i_type(OPC_BEQ, V0, ZERO, offset_to(here() + 32'd16)));  // Not taken
        emit(i_type(OPC_ADDIU, V0, V0, 16'd4));
        emit(i_type(OPC_ADDIU, V0, V0, 16'd8));
        emit(i_type(OPC_ADDIU, ZERO, T0, 16'(LOOPS)));
        loop_pc = here();
        emit(i_type(OPC_ADDIU, V0, V0, 16'h0010));
        emit(i_type(OPC_ADDIU, T0, T0, 16'hffff));
        emit(i_type(OPC_BNE, T0, ZERO, offset_to(loop_pc)));
        emit(i_type(OPC_ADDIU, V0, V0, 16'h1000));  // Delay slot runs on every pass
        emit(r_type(FN_JR, ZERO, ZERO, ZERO));
        emit(i_type(OPC_ADDIU, V0, V0, 16'h2000));
        expected = 32'd15 + 32'(LOOPS) * (32'h10 + 32'h1000) + 32'h2000;
        run_program("branches", expected);

        // R-type ops, then SB into two lanes and LW back
        a = sext(16'hfff9);
        b = sext(16'h0035);
        emit(i_type(OPC_ADDIU, ZERO, T0, 16'hfff9));
        emit(i_type(OPC_ADDIU, ZERO, T1, 16'h0035));
        emit(r_type(FN_ADDU, V0, T0, T1));
        emit(r_type(FN_SUBU, T2, T1, T0));
        emit(r_type(FN_ADDU, V0, V0, T2));
        emit(r_type(FN_AND, T2, T0, T1));
        emit(r_type(FN_ADDU, V0, V0, T2));
        emit(r_type(FN_OR, T2, T0, T1));
        emit(r_type(FN_ADDU, V0, V0, T2));
        emit(r_type(FN_SLT, T2, T0, T1));
        emit(r_type(FN_ADDU, V0, V0, T2));
        emit(r_type(FN_SLT, T2, T1, T0));
        emit(r_type(FN_ADDU, V0, V0, T2));
        emit(i_type(OPC_ADDIU, ZERO, ZERO, 16'h0055));  // Lost write to $zero
        emit(r_type(FN_ADDU, V0, V0, ZERO));
        emit(i_type(OPC_ADDIU, ZERO, S0, DATA_ADDR[15:0]));
        emit(i_type(OPC_ADDIU, ZERO, T2, 16'h005e));
        emit(i_type(OPC_SB, S0, T2, 16'd1));
        emit(i_type(OPC_ADDIU, ZERO, T2, 16'h01c7));  // Only the low byte lands
        emit(i_type(OPC_SB, S0, T2, 16'd3));
        emit(i_type(OPC_LW, S0, S1, 16'd0));
        emit(r_type(FN_JR, ZERO, ZERO, ZERO));
        emit(r_type(FN_ADDU, V0, V0, S1));
        mem_word        = DATA_INIT;
        mem_word[15:8]  = 8'h5e;
        mem_word[31:24] = 8'hc7;
        expected = (a + b) + (b - a) + (a & b) + (a | b) + mem_word
                 + 32'($signed(a) < $signed(b)) + 32'($signed(b) < $signed(a));
        run_program("alu_and_memory", expected);

        if (dut_i.props_i.error_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("Bus property assertions failed %0d times", dut_i.props_i.error_count);
            stop_on_failure();
        end
    end

endmodule

//--- mips_system.f
src/mips_isa_pkg.sv
src/avalon_pkg.sv
src/mips_regfile.sv
src/mips_alu.sv
src/mips_cpu.sv
src/avalon_ram.sv
src/mips_system.sv
tb/mips_system_props.sv
tb/mips_system_tb.sv

//--- Bender.yml
package:
  name: mips_system

sources:
  - src/mips_isa_pkg.sv
  - src/avalon_pkg.sv
  - src/mips_regfile.sv
  - src/mips_alu.sv
  - src/mips_cpu.sv
  - src/avalon_ram.sv
  - src/mips_system.sv
  - target: test
    files:
      - tb/mips_system_props.sv
      - tb/mips_system_tb.sv
